//--- phy_params.svh
// Byte group sizes are fixed at compile time; the RTL supports only 4 write beats and 2 read beats
`ifndef PHY_PARAMS_SVH
`define PHY_PARAMS_SVH

//##################################################
// Byte group geometry
//##################################################

// DQ pins in one byte group
`define PIN_WIDTH 8

// Beats per pin in one half-rate write word
`define RATE_MULT_OUT 4

// Full-rate beats per half-rate read word
`define RATE_MULT_IN 2

//##################################################
// Read word ordering
//##################################################

// 1 swaps the low and high lanes of each captured pair
`define RD_REVERSE_WORDS 0

`endif

//--- phy_data_pkg.sv
// Lane layout assumes two DDR edges per full-rate cycle; write words carry lane tN at N*PIN_WIDTH
`default_nettype none

`include "phy_params.svh"

package phy_data_pkg;

    // One full-rate lane, one bit per DQ pin
    typedef logic [`PIN_WIDTH-1:0] dq_lane_t;

    // Half-rate write word, index N is beat tN
    typedef dq_lane_t [`RATE_MULT_OUT-1:0] hr_wdata_t;

    // Write enable word, [0] fall half and [1] rise half
    typedef dq_lane_t [`RATE_MULT_OUT/2-1:0] hr_oe_t;

    // One captured full-rate pair, [0] low lane and [1] high lane
    typedef dq_lane_t [1:0] rd_pair_t;

    // Half-rate read word, [1] newer pair and [0] older pair
    typedef rd_pair_t [`RATE_MULT_IN-1:0] hr_rdata_t;

endpackage

`default_nettype wire

//--- phy_ctrl_pkg.sv
// Control types for the write phase machines and the read beat counter; read ratio must be 2 or more
`default_nettype none

`include "phy_params.svh"

package phy_ctrl_pkg;

    // Write phase of a half-rate word on the full-rate clock
    typedef enum logic [1:0] {
        WR_IDLE,    // No word in flight
        WR_FIRST,   // Word loaded, fall half goes out next
        WR_SECOND   // Rise half goes out next
    } wr_phase_e;

    // Position of the current full-rate beat inside a read word
    typedef logic [$clog2(`RATE_MULT_IN)-1:0] rd_phase_t;

endpackage

`default_nettype wire

//--- wr_ctrl_if.sv
// Load and select strobes for the write serializers; all signals are on pll_mem_clk, no handshake
`default_nettype none

interface wr_ctrl_if;

    logic data_load;    // DQ and DQ OE word capture
    logic data_sel;     // DQ rise half select
    logic dqs_load;     // DQS enable capture
    logic dqs_sel;      // DQS enable rise half select

    // Phase machine for DQ and DQ OE
    modport fsm_data (
        output data_load,
        output data_sel
    );

    // Phase machine for the DQS enable
    modport fsm_dqs (
        output dqs_load,
        output dqs_sel
    );

    // Serializers consume every strobe
    modport datapath (
        input data_load,
        input data_sel,
        input dqs_load,
        input dqs_sel
    );

endinterface

`default_nettype wire

//--- wr_phase_fsm.sv
// Write phase tracker; active must stay high for both cycles of a half-rate word, second one ignored
`default_nettype none

module wr_phase_fsm
    import phy_ctrl_pkg::*;
(
    input  logic pll_mem_clk,
    input  logic rst,
    input  logic active,
    output logic load,
    output logic sel
);

    wr_phase_e state;
    wr_phase_e state_nxt;

    // New word accepted only at the start or the end of a burst beat pair
    assign load = active && ((state == WR_IDLE) || (state == WR_SECOND));
    assign sel  = (state == WR_SECOND);

    always_comb
    begin
        state_nxt = state;
        case (state)
            WR_IDLE:
                if (active)
                    state_nxt = WR_FIRST;
            WR_FIRST:
                state_nxt = WR_SECOND;  // Held copy of the word is ignored
            WR_SECOND:
                if (active)
                    state_nxt = WR_FIRST;   // Back-to-back word
                else
                    state_nxt = WR_IDLE;
            default:
                state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge pll_mem_clk)
    begin
        if (rst)
            state <= WR_IDLE;
        else
            state <= state_nxt;
    end

    //##################################################
    // Checks
    //##################################################

    // Half-rate word is held for its ignored second cycle
    a_word_held_in_first: assert property (
        @(posedge pll_mem_clk) disable iff (rst)
        (state == WR_FIRST) |-> active
    );

    a_idle_after_reset: assert property (
        @(posedge pll_mem_clk)
        rst |=> (state == WR_IDLE)
    );

endmodule

`default_nettype wire

//--- hr_fr_serializer.sv
// Half-rate to full-rate beat pair; load and sel must come from a wr_phase_fsm on the same clock
`default_nettype none

module hr_fr_serializer #(
    parameter int WIDTH = 8
)
(
    input  logic             pll_mem_clk,
    input  logic             rst,
    input  logic             load,
    input  logic             sel,
    input  logic [WIDTH-1:0] fall_data,
    input  logic [WIDTH-1:0] rise_data,
    output logic [WIDTH-1:0] fr_out
);

    logic [WIDTH-1:0] fall_q;   // Captured fall half
    logic [WIDTH-1:0] rise_q;   // Captured rise half
    logic             beat_due;

    // Payload capture
    always_ff @(posedge pll_mem_clk)
    begin
        if (load)
        begin
            fall_q <= fall_data;
            rise_q <= rise_data;
        end
    end

    always_ff @(posedge pll_mem_clk)
    begin
        if (rst)
        begin
            beat_due <= 1'b0;
            fr_out   <= '0;
        end
        else
        begin
            beat_due <= load;       // Fall half due one cycle after the load
            if (sel)
                fr_out <= rise_q;
            else if (beat_due)
                fr_out <= fall_q;
            else
                fr_out <= '0;       // Idle lanes are driven low
        end
    end

    a_out_zero_after_reset: assert property (
        @(posedge pll_mem_clk)
        rst |=> (fr_out == '0)
    );

endmodule

`default_nettype wire

//--- wr_datapath.sv
// DQ, DQ OE and DQS enable serializers for one byte group; DQS enable lags the data by one cycle
`default_nettype none

`include "phy_params.svh"

module wr_datapath
    import phy_data_pkg::*;
(
    input  logic       pll_mem_clk,
    input  logic       rst,
    wr_ctrl_if.datapath ctrl,
    input  hr_wdata_t  write_data_in,
    input  hr_oe_t     write_oe_in,
    input  logic [1:0] output_strobe_ena,
    output dq_lane_t   dq_out_lo,
    output dq_lane_t   dq_out_hi,
    output dq_lane_t   dq_oe,
    output logic       dqs_oe
);

    logic dqs_oe_fr;    // DQS enable before retiming

    //##################################################
    // DQ data and output enable
    //##################################################

    hr_fr_serializer #(
        .WIDTH     (`PIN_WIDTH)
    ) u_ser_lo (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .load        (ctrl.data_load),
        .sel         (ctrl.data_sel),
        .fall_data   (write_data_in[0]),    // t0
        .rise_data   (write_data_in[2]),    // t2
        .fr_out      (dq_out_lo)
    );

    hr_fr_serializer #(
        .WIDTH     (`PIN_WIDTH)
    ) u_ser_hi (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .load        (ctrl.data_load),
        .sel         (ctrl.data_sel),
        .fall_data   (write_data_in[1]),    // t1
        .rise_data   (write_data_in[3]),    // t3
        .fr_out      (dq_out_hi)
    );

    hr_fr_serializer #(
        .WIDTH     (`PIN_WIDTH)
    ) u_ser_oe (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .load        (ctrl.data_load),
        .sel         (ctrl.data_sel),
        .fall_data   (write_oe_in[0]),
        .rise_data   (write_oe_in[1]),
        .fr_out      (dq_oe)
    );

    //##################################################
    // DQS output enable
    //##################################################

    hr_fr_serializer #(
        .WIDTH     (1)
    ) u_ser_dqs (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .load        (ctrl.dqs_load),
        .sel         (ctrl.dqs_sel),
        .fall_data   (output_strobe_ena[0]),
        .rise_data   (output_strobe_ena[1]),
        .fr_out      (dqs_oe_fr)
    );

    // Extra stage places the strobe window around the data eye
    always_ff @(posedge pll_mem_clk)
    begin
        if (rst)
            dqs_oe <= 1'b0;
        else
            dqs_oe <= dqs_oe_fr;
    end

endmodule

`default_nettype wire

//--- rd_beat_counter.sv
// Free-running read beat counter; phase 0 follows reset and read data is assumed to stream every cycle
`default_nettype none

`include "phy_params.svh"

module rd_beat_counter
    import phy_ctrl_pkg::*;
(
    input  logic      pll_mem_clk,
    input  logic      rst,
    output rd_phase_t phase,
    output logic      word_end
);

    localparam rd_phase_t LAST_PHASE = rd_phase_t'(`RATE_MULT_IN - 1);

    assign word_end = (phase == LAST_PHASE);    // Last beat of the read word

    always_ff @(posedge pll_mem_clk)
    begin
        if (rst)
            phase <= '0;
        else if (word_end)
            phase <= '0;
        else
            phase <= phase + rd_phase_t'(1);
    end

    // Word boundaries are evenly spaced
    a_word_end_period: assert property (
        @(posedge pll_mem_clk) disable iff (rst)
        word_end |=> !word_end ##(`RATE_MULT_IN - 1) word_end
    );

endmodule

`default_nettype wire

//--- rd_deserializer.sv
// Read capture and half-rate assembly; word_end must come from rd_beat_counter, no input gating
`default_nettype none

module rd_deserializer
    import phy_data_pkg::*;
#(
    parameter bit REVERSE = 1'b0
)
(
    input  logic      pll_mem_clk,
    input  logic      rst,
    input  logic      word_end,
    input  dq_lane_t  dq_in_lo,
    input  dq_lane_t  dq_in_hi,
    output hr_rdata_t rdata_hr,
    output logic      rdata_valid
);

    rd_pair_t rd_pair;      // Pair in word order
    rd_pair_t cap_stage1;   // Pair from the previous cycle
    rd_pair_t cap_stage2;   // Pair from two cycles back

    always_comb
    begin
        if (REVERSE)
        begin
            rd_pair[0] = dq_in_hi;
            rd_pair[1] = dq_in_lo;
        end
        else
        begin
            rd_pair[0] = dq_in_lo;
            rd_pair[1] = dq_in_hi;
        end
    end

    //##################################################
    // Full-rate capture stages
    //##################################################

    always_ff @(posedge pll_mem_clk)
    begin
        cap_stage1 <= rd_pair;
        cap_stage2 <= cap_stage1;
    end

    //##################################################
    // Half-rate word assembly
    //##################################################

    always_ff @(posedge pll_mem_clk)
    begin
        if (rst)
        begin
            rdata_hr    <= '0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rdata_valid <= word_end;    // One-cycle pulse per word
            if (word_end)
                rdata_hr <= {cap_stage1, cap_stage2};
        end
    end

endmodule

`default_nettype wire

//--- dqdqs_phy_top.sv
// DQ/DQS byte group datapath on pll_mem_clk only; pads, DQS toggling and extra pins are external
`default_nettype none

`include "phy_params.svh"

module dqdqs_phy_top
    import phy_data_pkg::*;
(
    input  logic       pll_mem_clk,
    input  logic       rst,
    input  hr_wdata_t  write_data_in,
    input  hr_oe_t     write_oe_in,
    input  logic [1:0] output_strobe_ena,
    input  dq_lane_t   dq_in_lo,
    input  dq_lane_t   dq_in_hi,
    output dq_lane_t   dq_out_lo,
    output dq_lane_t   dq_out_hi,
    output dq_lane_t   dq_oe,
    output logic       dqs_oe,
    output hr_rdata_t  rdata_hr,
    output logic       rdata_valid
);

    logic dq_wr_active;     // Any DQ enable bit set
    logic dqs_wr_active;    // Any DQS enable bit set
    logic rd_word_end;

    assign dq_wr_active  = |write_oe_in;
    assign dqs_wr_active = |output_strobe_ena;

    //##################################################
    // Write path
    //##################################################

    wr_ctrl_if wr_ctrl ();

    // DQ phase machine, drives the fsm_data strobes
    wr_phase_fsm u_wr_fsm_dq (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .active      (dq_wr_active),
        .load        (wr_ctrl.data_load),
        .sel         (wr_ctrl.data_sel)
    );

    // DQS phase machine, drives the fsm_dqs strobes
    wr_phase_fsm u_wr_fsm_dqs (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .active      (dqs_wr_active),
        .load        (wr_ctrl.dqs_load),
        .sel         (wr_ctrl.dqs_sel)
    );

    wr_datapath u_wr_datapath (
        .pll_mem_clk       (pll_mem_clk),
        .rst               (rst),
        .ctrl              (wr_ctrl),
        .write_data_in     (write_data_in),
        .write_oe_in       (write_oe_in),
        .output_strobe_ena (output_strobe_ena),
        .dq_out_lo         (dq_out_lo),
        .dq_out_hi         (dq_out_hi),
        .dq_oe             (dq_oe),
        .dqs_oe            (dqs_oe)
    );

    //##################################################
    // Read path
    //##################################################

    rd_beat_counter u_rd_beat_counter (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .phase       (),            // Word boundary is all the read path needs
        .word_end    (rd_word_end)
    );

    rd_deserializer #(
        .REVERSE     (`RD_REVERSE_WORDS)
    ) u_rd_deserializer (
        .pll_mem_clk (pll_mem_clk),
        .rst         (rst),
        .word_end    (rd_word_end),
        .dq_in_lo    (dq_in_lo),
        .dq_in_hi    (dq_in_hi),
        .rdata_hr    (rdata_hr),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

//--- tb_dqdqs_phy.sv
// Reads dqdqs_stimulus.txt from the run directory; expected values assume RD_REVERSE_WORDS is 0
`default_nettype none

module tb_dqdqs_phy
    import phy_data_pkg::*;
();

    localparam int    RST_CYCLES  = 8;
    localparam int    RST_TIMEOUT = 4 * RST_CYCLES;   // Cycles allowed for reset release
    localparam int    MAX_LINES   = 1000;
    localparam string STIM_FILE   = "dqdqs_stimulus.txt";

    logic       pll_mem_clk;
    logic       rst;
    hr_wdata_t  write_data_in;
    hr_oe_t     write_oe_in;
    logic [1:0] output_strobe_ena;
    dq_lane_t   dq_in_lo;
    dq_lane_t   dq_in_hi;
    dq_lane_t   dq_out_lo;
    dq_lane_t   dq_out_hi;
    dq_lane_t   dq_oe;
    logic       dqs_oe;
    hr_rdata_t  rdata_hr;
    logic       rdata_valid;

    dqdqs_phy_top dut (
        .pll_mem_clk       (pll_mem_clk),
        .rst               (rst),
        .write_data_in     (write_data_in),
        .write_oe_in       (write_oe_in),
        .output_strobe_ena (output_strobe_ena),
        .dq_in_lo          (dq_in_lo),
        .dq_in_hi          (dq_in_hi),
        .dq_out_lo         (dq_out_lo),
        .dq_out_hi         (dq_out_hi),
        .dq_oe             (dq_oe),
        .dqs_oe            (dqs_oe),
        .rdata_hr          (rdata_hr),
        .rdata_valid       (rdata_valid)
    );

    //##################################################
    // Clock and reset
    //##################################################

    initial
    begin
        pll_mem_clk = 1'b0;
    end

    always #10 pll_mem_clk = ~pll_mem_clk;     // Period 20

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge pll_mem_clk);
        rst <= 1'b0;
    end

    //##################################################
    // Error handling and compare tasks
    //##################################################

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_lane(input string name, input dq_lane_t actual, input dq_lane_t expected);
        if (actual !== expected)
            stop_with_failure($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                $time, name, expected, actual));
    endtask

    task automatic check_rdata(input string name, input hr_rdata_t actual,
                               input hr_rdata_t expected);
        if (actual !== expected)
            stop_with_failure($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                $time, name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            stop_with_failure($sformatf("FAIL time=%0t signal=%s expected=%b actual=%b",
                $time, name, expected, actual));
    endtask

    // Blank lines and lines starting with # carry no cycle
    function automatic bit is_data_line(input string text);
        byte first;
        if (text.len() == 0)
            return 1'b0;
        first = text.getc(0);
        return (first != "#") && (first != "\n") && (first != "\r");
    endfunction

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0)
        begin
            @(posedge pll_mem_clk);
            cycles++;
            if (cycles > RST_TIMEOUT)
                stop_with_failure("Reset was not released within the timeout");
        end
    endtask

    //##################################################
    // Stimulus and checking, one file line per cycle
    //##################################################

    initial
    begin
        int          fd;
        int          line_no;
        int          cycles;
        int          fields;
        string       text;
        logic [31:0] f_wdata;
        logic [15:0] f_oe;
        logic [1:0]  f_ose;
        logic [7:0]  f_in_lo;
        logic [7:0]  f_in_hi;
        logic [7:0]  e_lo;
        logic [7:0]  e_hi;
        logic [7:0]  e_oe;
        logic        e_dqs;
        logic [31:0] e_rdata;
        logic        e_valid;

        write_data_in     = '0;
        write_oe_in       = '0;
        output_strobe_ena = 2'b00;
        dq_in_lo          = '0;
        dq_in_hi          = '0;
        line_no           = 0;
        cycles            = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
            stop_with_failure("Cannot open the stimulus file dqdqs_stimulus.txt");

        wait_reset_release();   // Returns on the first rising edge out of reset

        while ($fgets(text, fd) != 0)
        begin
            line_no++;
            if (line_no > MAX_LINES)
                stop_with_failure("Stimulus file is longer than the line limit");
            if (is_data_line(text))
            begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h",
                    f_wdata, f_oe, f_ose, f_in_lo, f_in_hi,
                    e_lo, e_hi, e_oe, e_dqs, e_rdata, e_valid);
                if (fields != 11)
                    stop_with_failure($sformatf(
                        "Stimulus line %0d does not hold 11 hex fields", line_no));
                write_data_in     <= f_wdata;
                write_oe_in       <= f_oe;
                output_strobe_ena <= f_ose;
                dq_in_lo          <= f_in_lo;
                dq_in_hi          <= f_in_hi;
                @(negedge pll_mem_clk);     // Registered outputs settled
                check_lane("dq_out_lo", dq_out_lo, e_lo);
                check_lane("dq_out_hi", dq_out_hi, e_hi);
                check_lane("dq_oe", dq_oe, e_oe);
                check_bit("dqs_oe", dqs_oe, e_dqs);
                check_rdata("rdata_hr", rdata_hr, e_rdata);
                check_bit("rdata_valid", rdata_valid, e_valid);
                cycles++;
                @(posedge pll_mem_clk);
            end
        end
        $fclose(fd);

        if (cycles == 0)
            stop_with_failure("Stimulus file holds no cycle lines");
        else
        begin
            $display("%0d cycles checked", cycles);
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dqdqs_stimulus.txt
# Inputs: write_data_in write_oe_in output_strobe_ena dq_in_lo dq_in_hi, then expected:
# dq_out_lo dq_out_hi dq_oe dqs_oe rdata_hr rdata_valid (all hex, one line per cycle)
00000000 0000 0 A0 50   00 00 00 0 00000000 0
00000000 0000 0 A1 51   00 00 00 0 00000000 1
00000000 0000 0 A2 52   00 00 00 0 00000000 0
44332211 F00F 0 A3 53   00 00 00 0 51A150A0 1
44332211 F00F 0 A4 54   00 00 00 0 51A150A0 0
00000000 0000 0 A5 55   11 22 0F 0 53A352A2 1
00000000 0000 0 A6 56   33 44 F0 0 53A352A2 0
00000000 0000 0 A7 57   00 00 00 0 55A554A4 1
00000000 0000 0 A8 58   00 00 00 0 55A554A4 0
D4C3B2A1 3C5A 3 A9 59   00 00 00 0 57A756A6 1
0F1E2D3C 81E7 3 AA 5A   00 00 00 0 57A756A6 0
0F1E2D3C 81E7 0 AB 5B   A1 B2 5A 0 59A958A8 1
0F1E2D3C 81E7 0 AC 5C   C3 D4 3C 1 59A958A8 0
00000000 0000 0 AD 5D   3C 2D E7 1 5BAB5AAA 1
00000000 0000 0 AE 5E   1E 0F 81 0 5BAB5AAA 0
00000000 0000 0 AF 5F   00 00 00 0 5DAD5CAC 1
00000000 0000 0 B0 60   00 00 00 0 5DAD5CAC 0
00000000 0000 2 B1 61   00 00 00 0 5FAF5EAE 1
00000000 0000 2 B2 62   00 00 00 0 5FAF5EAE 0
00000000 0000 0 B3 63   00 00 00 0 61B160B0 1
00000000 0000 0 B4 64   00 00 00 0 61B160B0 0
00000000 0000 0 B5 65   00 00 00 1 63B362B2 1
00000000 0000 0 B6 66   00 00 00 0 63B362B2 0
00000000 0000 1 B7 67   00 00 00 0 65B564B4 1
00000000 0000 1 B8 68   00 00 00 0 65B564B4 0
00000000 0000 2 B9 69   00 00 00 0 67B766B6 1
00000000 0000 2 BA 6A   00 00 00 1 67B766B6 0
12345678 00FF 0 BB 6B   00 00 00 0 69B968B8 1
12345678 00FF 0 BC 6C   00 00 00 0 69B968B8 0
6E5D4C3B FF00 0 BD 6D   78 56 FF 1 6BBB6ABA 1
6E5D4C3B FF00 0 BE 6E   34 12 00 0 6BBB6ABA 0
00000000 0000 0 BF 6F   3B 4C 00 0 6DBD6CBC 1
00000000 0000 0 C0 70   5D 6E FF 0 6DBD6CBC 0
00000000 0000 0 C1 71   00 00 00 0 6FBF6EBE 1
00000000 0000 0 C2 72   00 00 00 0 6FBF6EBE 0

//--- sim.f
+incdir+.
phy_data_pkg.sv
phy_ctrl_pkg.sv
wr_ctrl_if.sv
wr_phase_fsm.sv
hr_fr_serializer.sv
wr_datapath.sv
rd_beat_counter.sv
rd_deserializer.sv
dqdqs_phy_top.sv
tb_dqdqs_phy.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dqdqs_phy \
    -f sim.f \
    --Mdir obj_dir \
    -o tb_dqdqs_phy
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_dqdqs_phy
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0
